// File: hw/bus_pkg.sv
package bus_pkg;

    localparam int NUM_DEVICES = 8;
    localparam int ID_W        = 3;
    localparam int ADDR_W      = 12;
    localparam int DATA_W      = 32;

    // slot ids on the shared bus, unused ids never request
    localparam logic [ID_W-1:0] RAM_ID  = 3'd0;
    localparam logic [ID_W-1:0] UART_ID = 3'd6;
    localparam logic [ID_W-1:0] HOST_ID = 3'd7;

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_WRITE,
        OP_READ,
        OP_RESP
    } bus_op_e;

    typedef struct packed {
        logic              valid;
        bus_op_e           op;
        logic [ID_W-1:0]   dst;
        logic [ID_W-1:0]   src;    // who to answer
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } bus_msg_t;

endpackage

// File: hw/dev_pkg.sv
package dev_pkg;

    localparam int RAM_DEPTH = 1024;
    localparam int RAM_AW    = $clog2(RAM_DEPTH);

    localparam int UART_CLKS_PER_BIT = 16;

    // received uart bytes land here, one per word
    localparam logic [bus_pkg::ADDR_W-1:0] RX_BASE = 12'd256;

    // command from the outside host, op is write or read only
    typedef struct packed {
        bus_pkg::bus_op_e              op;
        logic [bus_pkg::ID_W-1:0]      dst;
        logic [bus_pkg::ADDR_W-1:0]    addr;
        logic [bus_pkg::DATA_W-1:0]    data;
    } host_cmd_t;

endpackage

// File: hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                            clk50MHz,
    input  logic                            rst,
    input  logic [bus_pkg::NUM_DEVICES-1:0] req,
    input  bus_pkg::bus_msg_t               msg_in [bus_pkg::NUM_DEVICES],
    output logic [bus_pkg::NUM_DEVICES-1:0] ack,
    output bus_pkg::bus_msg_t               bus
);
    import bus_pkg::*;

    logic [NUM_DEVICES-1:0] eligible;
    logic [ID_W-1:0]        last_id;
    logic [ID_W-1:0]        cand;
    logic [ID_W-1:0]        grant_id;
    logic                   grant_valid;

    assign eligible = req & ~ack;  // acked slot sits out this edge

    // round robin, starting just after the last winner
    always_comb begin
        grant_valid = 1'b0;
        grant_id    = last_id;
        cand        = last_id;
        for (int i = 1; i <= NUM_DEVICES; i++) begin
            cand = last_id + ID_W'(i);
            if (!grant_valid && eligible[cand]) begin
                grant_valid = 1'b1;
                grant_id    = cand;
            end
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            last_id   <= ID_W'(NUM_DEVICES - 1);  // slot 0 first
            ack       <= '0;
            bus.valid <= 1'b0;
        end else if (grant_valid) begin
            bus       <= msg_in[grant_id];
            bus.valid <= 1'b1;
            ack       <= NUM_DEVICES'(1) << grant_id;
            last_id   <= grant_id;
        end else begin
            bus.valid <= 1'b0;
            ack       <= '0;
        end
    end

endmodule

// File: hw/host_port.sv
`timescale 1ns/1ps

module host_port (
    input  logic                        clk50MHz,
    input  logic                        rst,
    input  logic                        cmd_valid,
    input  dev_pkg::host_cmd_t          cmd,
    output logic                        cmd_ready,
    output logic                        rsp_valid,
    output logic [bus_pkg::DATA_W-1:0]  rsp_data,
    output logic                        req,
    input  logic                        ack,
    output bus_pkg::bus_msg_t           msg_out,
    input  bus_pkg::bus_msg_t           bus
);
    import bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_RSP
    } state_e;

    state_e state;
    logic   rsp_hit;

    assign cmd_ready = (state == IDLE);
    assign req       = (state == SEND);

    // answer from the device we asked
    assign rsp_hit = bus.valid && bus.op == OP_RESP && bus.dst == HOST_ID
                     && bus.src == msg_out.dst;

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            state     <= IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        msg_out <= '{valid: 1'b1, op: cmd.op, dst: cmd.dst, src: HOST_ID,
                                     addr: cmd.addr, data: cmd.data};
                        state   <= SEND;
                    end
                end
                SEND: begin
                    if (ack) begin
                        if (msg_out.op == OP_READ) begin
                            state <= WAIT_RSP;
                        end else begin
                            state <= IDLE;  // write done once on the bus
                        end
                    end
                end
                WAIT_RSP: begin
                    if (rsp_hit) begin
                        rsp_valid <= 1'b1;
                        rsp_data  <= bus.data;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: hw/ram_device.sv
`timescale 1ns/1ps

module ram_device (
    input  logic              clk50MHz,
    input  logic              rst,
    input  bus_pkg::bus_msg_t bus,
    input  logic              ack,
    output logic              req,
    output bus_pkg::bus_msg_t msg_out
);
    import bus_pkg::*;
    import dev_pkg::*;

    logic [DATA_W-1:0] mem [RAM_DEPTH];
    logic [RAM_AW-1:0] word_addr;
    logic              hit;
    logic              wr_hit;
    logic              rd_hit;

    assign hit       = bus.valid && bus.dst == RAM_ID;
    assign wr_hit    = hit && bus.op == OP_WRITE;
    assign rd_hit    = hit && bus.op == OP_READ;
    assign word_addr = bus.addr[RAM_AW-1:0];  // upper address bits ignored

    always_ff @(posedge clk50MHz) begin
        if (wr_hit) begin
            mem[word_addr] <= bus.data;
        end
    end

    // read data goes back to whoever asked
    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            req <= 1'b0;
        end else if (rd_hit) begin
            req     <= 1'b1;
            msg_out <= '{valid: 1'b1, op: OP_RESP, dst: bus.src, src: RAM_ID,
                         addr: bus.addr, data: mem[word_addr]};
        end else if (ack) begin
            req <= 1'b0;
        end
    end

endmodule

// File: hw/uart_device.sv
`timescale 1ns/1ps

module uart_device #(
    parameter int clks_per_bit = dev_pkg::UART_CLKS_PER_BIT
) (
    input  logic              clk50MHz,
    input  logic              rst,
    input  bus_pkg::bus_msg_t bus,
    input  logic              ack,
    output logic              req,
    output bus_pkg::bus_msg_t msg_out,
    output logic              hold_full,
    input  logic              rx,
    output logic              tx
);
    import bus_pkg::*;
    import dev_pkg::*;

    localparam int               CNT_W   = $clog2(clks_per_bit);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(clks_per_bit - 1);
    localparam logic [CNT_W-1:0] BIT_MID = CNT_W'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    tx_state_e         tx_state;
    logic [CNT_W-1:0]  tx_cnt;
    logic [2:0]        tx_bit;
    logic [7:0]        tx_shift;
    logic              hold_valid;
    logic [7:0]        hold_byte;
    rx_state_e         rx_state;
    logic [1:0]        rx_sync;
    logic [CNT_W-1:0]  rx_cnt;
    logic [2:0]        rx_bit;
    logic [7:0]        rx_shift;
    logic [ADDR_W-1:0] rx_count;
    logic              rx_done;
    logic              rd_pend;
    logic [ID_W-1:0]   rd_src;
    logic              wr_hit;
    logic              rd_hit;
    logic              slot_free;

    assign wr_hit    = bus.valid && bus.dst == UART_ID && bus.op == OP_WRITE;
    assign rd_hit    = bus.valid && bus.dst == UART_ID && bus.op == OP_READ;
    assign hold_full = hold_valid;
    assign slot_free = !req || ack;
    assign rx_done   = rx_state == RX_STOP && rx_cnt == BIT_END && rx_sync[1];

    // 8N1 transmitter, lsb first
    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            tx_state   <= TX_IDLE;
            tx         <= 1'b1;
            tx_cnt     <= '0;
            tx_bit     <= '0;
            hold_valid <= 1'b0;
        end else begin
            if (tx_state != TX_IDLE) begin
                tx_cnt <= (tx_cnt == BIT_END) ? '0 : tx_cnt + 1'b1;
            end
            case (tx_state)
                TX_IDLE: begin
                    if (hold_valid || wr_hit) begin
                        tx_shift   <= hold_valid ? hold_byte : bus.data[7:0];
                        hold_valid <= 1'b0;
                        tx         <= 1'b0;  // start bit
                        tx_state   <= TX_START;
                    end
                end
                TX_START: begin
                    if (tx_cnt == BIT_END) begin
                        tx       <= tx_shift[0];
                        tx_bit   <= '0;
                        tx_state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (tx_cnt == BIT_END) begin
                        if (tx_bit == 3'd7) begin
                            tx       <= 1'b1;
                            tx_state <= TX_STOP;
                        end else begin
                            tx_shift <= tx_shift >> 1;
                            tx       <= tx_shift[1];
                            tx_bit   <= tx_bit + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (tx_cnt == BIT_END) begin
                        tx_state <= TX_IDLE;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
            if (wr_hit && (tx_state != TX_IDLE || hold_valid)) begin  // line busy
                hold_valid <= 1'b1;
                hold_byte  <= bus.data[7:0];
            end
        end
    end

    // receiver, samples mid-bit
    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            rx_sync  <= 2'b11;
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_cnt  <= rx_cnt + 1'b1;
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_sync[1]) begin
                        rx_state <= RX_START;
                    end
                end
                RX_START: begin
                    if (rx_cnt == BIT_MID) begin
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;  // glitch check
                    end
                end
                RX_DATA: begin
                    if (rx_cnt == BIT_END) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_sync[1], rx_shift[7:1]};
                        rx_bit   <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (rx_cnt == BIT_END) begin
                        rx_state <= RX_IDLE;
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    // bus master side, a new byte wins over a parked read answer
    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            req      <= 1'b0;
            rd_pend  <= 1'b0;
            rx_count <= '0;
        end else begin
            if (ack) begin
                req <= 1'b0;
            end
            if (rd_hit) begin
                rd_pend <= 1'b1;
                rd_src  <= bus.src;
            end
            if (slot_free && rx_done) begin
                req      <= 1'b1;
                msg_out  <= '{valid: 1'b1, op: OP_WRITE, dst: RAM_ID, src: UART_ID,
                              addr: RX_BASE + rx_count, data: DATA_W'(rx_shift)};
                rx_count <= rx_count + 1'b1;
            end else if (slot_free && (rd_pend || rd_hit)) begin
                req     <= 1'b1;
                rd_pend <= 1'b0;
                msg_out <= '{valid: 1'b1, op: OP_RESP, dst: rd_hit ? bus.src : rd_src,
                             src: UART_ID, addr: '0, data: DATA_W'(rx_count)};
            end
        end
    end

endmodule

// File: hw/soc_bus_system.sv
`timescale 1ns/1ps

module soc_bus_system (
    input  logic                       clk50MHz,
    input  logic                       rst,
    input  logic                       cmd_valid,
    input  dev_pkg::host_cmd_t         cmd,
    output logic                       cmd_ready,
    output logic                       rsp_valid,
    output logic [bus_pkg::DATA_W-1:0] rsp_data,
    input  logic                       rx,
    output logic                       tx
);
    import bus_pkg::*;

    logic [NUM_DEVICES-1:0] dev_req;
    logic [NUM_DEVICES-1:0] dev_ack;
    bus_msg_t               dev_msg [NUM_DEVICES];
    bus_msg_t               bus;
    logic                   host_req;
    logic                   ram_req;
    logic                   uart_req;
    bus_msg_t               host_msg;
    bus_msg_t               ram_msg;
    bus_msg_t               uart_msg;
    logic                   uart_hold_full;
    logic                   host_stall;

    // uart write waits while its holding byte is taken
    assign host_stall = uart_hold_full && host_msg.dst == UART_ID && host_msg.op == OP_WRITE;

    always_comb begin
        dev_req          = '0;  // empty slots stay quiet
        dev_req[RAM_ID]  = ram_req;
        dev_req[UART_ID] = uart_req;
        dev_req[HOST_ID] = host_req && !host_stall;
        for (int i = 0; i < NUM_DEVICES; i++) begin
            dev_msg[i] = '0;
        end
        dev_msg[RAM_ID]  = ram_msg;
        dev_msg[UART_ID] = uart_msg;
        dev_msg[HOST_ID] = host_msg;
    end

    bus_arbiter arbiter (
        .clk50MHz (clk50MHz),
        .rst      (rst),
        .req      (dev_req),
        .msg_in   (dev_msg),
        .ack      (dev_ack),
        .bus      (bus)
    );

    host_port host (
        .clk50MHz  (clk50MHz),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .req       (host_req),
        .ack       (dev_ack[HOST_ID]),
        .msg_out   (host_msg),
        .bus       (bus)
    );

    ram_device ram (
        .clk50MHz (clk50MHz),
        .rst      (rst),
        .bus      (bus),
        .ack      (dev_ack[RAM_ID]),
        .req      (ram_req),
        .msg_out  (ram_msg)
    );

    uart_device uart (
        .clk50MHz  (clk50MHz),
        .rst       (rst),
        .bus       (bus),
        .ack       (dev_ack[UART_ID]),
        .req       (uart_req),
        .msg_out   (uart_msg),
        .hold_full (uart_hold_full),
        .rx        (rx),
        .tx        (tx)
    );

endmodule

// File: dv/tb_soc_bus_system.sv
`timescale 1ns/1ps

module tb_soc_bus_system;
    import bus_pkg::*;
    import dev_pkg::*;

    logic                clk50MHz;
    logic                rst;
    logic                cmd_valid;
    host_cmd_t           cmd;
    logic                cmd_ready;
    logic                rsp_valid;
    logic [DATA_W-1:0]   rsp_data;
    logic                rx;
    logic                tx;

    logic [DATA_W-1:0]   model_mem [RAM_DEPTH];
    int                  model_rx_count = 0;
    logic [DATA_W-1:0]   exp_q [$];   // expected read data in issue order
    logic [7:0]          tx_exp [$];
    logic [7:0]          tx_got [$];
    logic [ADDR_W-1:0]   wr_addrs [$];
    int                  errors = 0;
    int                  checks = 0;

    soc_bus_system dut0 (
        .clk50MHz  (clk50MHz),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rx        (rx),
        .tx        (tx)
    );

    initial begin
        clk50MHz = 1'b0;
        forever #10 clk50MHz = ~clk50MHz;
    end

    function automatic logic [DATA_W-1:0] expected_read(input logic [ID_W-1:0] dst,
                                                        input logic [ADDR_W-1:0] addr);
        if (dst == UART_ID) begin
            return DATA_W'(model_rx_count);
        end
        return model_mem[addr[RAM_AW-1:0]];
    endfunction

    function automatic logic [ADDR_W-1:0] rand_ram_addr();
        int a;
        a = $urandom_range(767, 0);
        if (a >= 256) begin
            a += 256;  // step over the rx area
        end
        return {2'($urandom_range(3, 0)), 10'(a)};
    endfunction

    task automatic abort_run(input string why);
        $display("timeout: %s at %0t", why, $time);
        $display("Regression failed");
        $finish;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk50MHz);
        while (!cmd_ready) begin
            n++;
            if (n > 5000) abort_run("cmd_ready never came back");
            @(negedge clk50MHz);
        end
    endtask

    task automatic wait_rsp();
        int n;
        n = 0;
        @(negedge clk50MHz);
        while (!rsp_valid) begin
            n++;
            if (n > 5000) abort_run("no read response");
            @(negedge clk50MHz);
        end
    endtask

    task automatic wait_tx_bytes(input int count);
        int n;
        n = 0;
        @(negedge clk50MHz);
        while (tx_got.size() < count) begin
            n++;
            if (n > 5000) abort_run("tx bytes missing");
            @(negedge clk50MHz);
        end
    endtask

    task automatic host_op(input bus_op_e op, input logic [ID_W-1:0] dst,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        host_cmd_t c;
        c = '{op: op, dst: dst, addr: addr, data: data};
        if (op == OP_READ) begin
            exp_q.push_back(expected_read(dst, addr));
        end else if (dst == UART_ID) begin
            tx_exp.push_back(data[7:0]);
        end else begin
            model_mem[addr[RAM_AW-1:0]] = data;
        end
        wait_ready();
        @(posedge clk50MHz);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk50MHz);
        cmd_valid <= 1'b0;  // accepted on this edge
        if (op == OP_READ) begin
            wait_rsp();
        end else begin
            wait_ready();
        end
    endtask

    task automatic send_rx_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk50MHz);
            rx <= frame[i];
            repeat (UART_CLKS_PER_BIT - 1) @(posedge clk50MHz);
        end
        repeat (3 * UART_CLKS_PER_BIT) @(posedge clk50MHz);  // idle gap
        model_mem[RAM_AW'(int'(RX_BASE) + model_rx_count)] = DATA_W'(b);
        model_rx_count++;
    endtask

    task automatic report_test(input string name, input int err_before);
        @(posedge clk50MHz);  // let the last response be compared
        $display("test %s done with %0d errors", name, errors - err_before);
    endtask

    // compares every read response with the oldest expected value
    always @(negedge clk50MHz) begin : compare_rsp
        logic [DATA_W-1:0] exp;
        if (!rst && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("read response at %0t with no read outstanding", $time);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                checks++;
                if (rsp_data !== exp) begin
                    $display("Mismatch at %0t: read data %h, expected %h", $time, rsp_data, exp);
                    errors++;
                end
            end
        end
    end

    // serial line receiver on tx sampling mid-bit
    initial begin : tx_monitor
        logic [7:0] b;
        forever begin
            @(negedge clk50MHz);
            if (!rst && tx === 1'b0) begin
                repeat (UART_CLKS_PER_BIT / 2) @(negedge clk50MHz);
                for (int i = 0; i < 8; i++) begin
                    repeat (UART_CLKS_PER_BIT) @(negedge clk50MHz);
                    b[i] = tx;
                end
                repeat (UART_CLKS_PER_BIT) @(negedge clk50MHz);
                if (tx !== 1'b1) begin
                    $display("tx stop bit missing at %0t", $time);
                    errors++;
                end
                tx_got.push_back(b);
            end
        end
    end

    initial begin : main
        int                err0;
        int                first;
        logic [ADDR_W-1:0] a;
        void'($urandom(38));
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        rx        = 1'b1;
        repeat (10) @(posedge clk50MHz);
        rst <= 1'b0;

        err0 = errors;
        @(negedge clk50MHz);
        checks++;
        if (cmd_ready !== 1'b1 || rsp_valid !== 1'b0 || tx !== 1'b1) begin
            $display("Mismatch at %0t: idle outputs ready %b rsp %b tx %b", $time,
                     cmd_ready, rsp_valid, tx);
            errors++;
        end
        report_test("reset_state", err0);

        err0 = errors;
        for (int i = 0; i < 20; i++) begin
            a = rand_ram_addr();
            wr_addrs.push_back(a);
            host_op(OP_WRITE, RAM_ID, a, $urandom());
        end
        foreach (wr_addrs[i]) host_op(OP_READ, RAM_ID, wr_addrs[i], '0);
        report_test("ram_write_read", err0);

        err0 = errors;
        for (int i = 0; i < 4; i++) host_op(OP_WRITE, UART_ID, '0, $urandom());
        wait_tx_bytes(4);
        foreach (tx_exp[i]) begin
            checks++;
            if (tx_got[i] !== tx_exp[i]) begin
                $display("Mismatch at %0t: tx byte %0d is %h, expected %h", $time, i,
                         tx_got[i], tx_exp[i]);
                errors++;
            end
        end
        report_test("uart_tx", err0);

        err0  = errors;
        first = model_rx_count;
        repeat (5) send_rx_byte(8'($urandom()));
        for (int i = first; i < model_rx_count; i++) begin
            host_op(OP_READ, RAM_ID, RX_BASE + ADDR_W'(i), '0);
        end
        host_op(OP_READ, UART_ID, '0, '0);
        report_test("uart_rx_to_ram", err0);

        err0  = errors;
        first = model_rx_count;
        fork
            repeat (6) send_rx_byte(8'($urandom()));
            for (int i = 0; i < 30; i++) begin
                repeat ($urandom_range(40, 0)) @(posedge clk50MHz);
                if ($urandom_range(1, 0) == 1) begin
                    a = rand_ram_addr();
                    wr_addrs.push_back(a);
                    host_op(OP_WRITE, RAM_ID, a, $urandom());
                end else begin
                    a = wr_addrs[$urandom_range(wr_addrs.size() - 1, 0)];
                    host_op(OP_READ, RAM_ID, a, '0);
                end
            end
        join
        for (int i = first; i < model_rx_count; i++) begin
            host_op(OP_READ, RAM_ID, RX_BASE + ADDR_W'(i), '0);
        end
        host_op(OP_READ, UART_ID, '0, '0);
        report_test("two_masters", err0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: soc_bus_system.f
hw/bus_pkg.sv
hw/dev_pkg.sv
hw/bus_arbiter.sv
hw/host_port.sv
hw/ram_device.sv
hw/uart_device.sv
hw/soc_bus_system.sv
dv/tb_soc_bus_system.sv

// File: Bender.yml
package:
  name: soc_bus_system

sources:
  - hw/bus_pkg.sv
  - hw/dev_pkg.sv
  - hw/bus_arbiter.sv
  - hw/host_port.sv
  - hw/ram_device.sv
  - hw/uart_device.sv
  - hw/soc_bus_system.sv
  - target: test
    files:
      - dv/tb_soc_bus_system.sv
